// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

    always #5 clk = ~clk;  // 10 ns period.

endmodule

// ==== sim/tb_rv_exec.sv ====
`timescale 1ns/1ps

module tb_rv_exec;
    localparam logic [31:0] RESET_PC = 32'd0;
    localparam int PROG_WORDS = 64;

    logic        clk, rst_n;
    logic [31:0] fetch_pc, inst, commit_pc, commit_data;
    logic        inst_valid, commit_ready, commit_valid, commit_wen;
    logic [4:0]  commit_rd;

    logic [31:0] prog [0:PROG_WORDS-1];
    int          prog_len;
    logic [31:0] loop_pc;
    int          mismatches = 0;
    int          other_errors = 0;
    int          commits = 0;
    int          loop_hits = 0;
    logic [15:0] lfsr = 16'd91;

    // Architectural model state.
    logic [31:0] m_pc;
    logic [31:0] m_regs [0:31];
    logic [31:0] exp_next, exp_data;
    logic [4:0]  exp_rd;
    logic        exp_wen;

    tb_clock clk0 (.clk(clk), .rst_n(rst_n));

    rv_exec_core #(.RESET_PC(RESET_PC)) dut0 (
        .clk(clk), .rst_n(rst_n), .fetch_pc(fetch_pc), .inst(inst),
        .inst_valid(inst_valid), .commit_ready(commit_ready),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_rd(commit_rd),
        .commit_wen(commit_wen), .commit_data(commit_data)
    );

    assign inst = prog[fetch_pc[7:2]];

    // ~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic put(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = {i[24:0] ^ 25'h15a5a5, 7'b0001011};  // Unsupported custom-0 words.
        end
        prog_len = 0;
        put(enc_i(12'd5, 5'd0, 3'd0, 5'd1, 7'b0010011));      // addi x1, x0, 5
        put(enc_i(-12'sd3, 5'd0, 3'd0, 5'd2, 7'b0010011));    // addi x2, x0, -3
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));            // add (forwarded)
        put(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd4));            // sub
        put(enc_r(7'h00, 5'd3, 5'd1, 3'd1, 5'd5));            // sll
        put(enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd6));            // slt
        put(enc_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd7));            // sltu
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd8));            // xor
        put(enc_r(7'h00, 5'd3, 5'd2, 3'd5, 5'd9));            // srl
        put(enc_r(7'h20, 5'd3, 5'd2, 3'd5, 5'd10));           // sra
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd11));           // or
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd12));           // and
        put(enc_i(12'h055, 5'd8, 3'd4, 5'd13, 7'b0010011));   // xori
        put(enc_i(12'd4, 5'd1, 3'd1, 5'd14, 7'b0010011));     // slli
        put(enc_i(12'h401, 5'd2, 3'd5, 5'd15, 7'b0010011));   // srai
        put(enc_i(12'd28, 5'd2, 3'd5, 5'd16, 7'b0010011));    // srli
        put(enc_i(12'd7, 5'd2, 3'd3, 5'd24, 7'b0010011));     // sltiu
        put({20'h12345, 5'd17, 7'b0110111});                  // lui
        put({20'h00001, 5'd18, 7'b0010111});                  // auipc
        put(enc_i(12'd7, 5'd1, 3'd0, 5'd0, 7'b0010011));      // write to x0
        put(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd19));           // reads x0
        put({20'h0abcd, 5'd5, 7'b0001011});                   // unsupported opcode
        // Taken branches skip one poison instruction.
        put(enc_b(13'd8, 5'd1, 5'd1, 3'd0));                  // beq taken
        put(enc_i(12'd99, 5'd0, 3'd0, 5'd20, 7'b0010011));
        put(enc_b(13'd8, 5'd1, 5'd1, 3'd1));                  // bne not taken
        put(enc_b(13'd8, 5'd2, 5'd1, 3'd1));                  // bne taken
        put(enc_i(12'd98, 5'd0, 3'd0, 5'd20, 7'b0010011));
        put(enc_b(13'd8, 5'd1, 5'd2, 3'd4));                  // blt taken
        put(enc_i(12'd97, 5'd0, 3'd0, 5'd20, 7'b0010011));
        put(enc_b(13'd8, 5'd1, 5'd2, 3'd5));                  // bge not taken
        put(enc_b(13'd8, 5'd2, 5'd1, 3'd5));                  // bge taken
        put(enc_i(12'd96, 5'd0, 3'd0, 5'd20, 7'b0010011));
        put(enc_b(13'd8, 5'd2, 5'd1, 3'd6));                  // bltu taken
        put(enc_i(12'd95, 5'd0, 3'd0, 5'd20, 7'b0010011));
        put(enc_b(13'd8, 5'd2, 5'd1, 3'd7));                  // bgeu not taken
        put(enc_b(13'd8, 5'd1, 5'd2, 3'd7));                  // bgeu taken
        put(enc_i(12'd94, 5'd0, 3'd0, 5'd20, 7'b0010011));
        put(enc_j(21'd8, 5'd21));                             // jal
        put(enc_i(12'd93, 5'd0, 3'd0, 5'd20, 7'b0010011));
        put({20'h00000, 5'd22, 7'b0010111});                  // auipc x22, 0
        put(enc_i(12'd13, 5'd22, 3'd0, 5'd23, 7'b1100111));   // jalr, bit 0 dropped
        put(enc_i(12'd92, 5'd0, 3'd0, 5'd20, 7'b0010011));
        put(enc_r(7'h00, 5'd23, 5'd21, 3'd0, 5'd25));         // uses both links
        loop_pc = 32'(prog_len) * 4;
        put(enc_j(21'd0, 5'd0));                              // Self-loop.
    end

    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        logic [31:0] w, imm_i, imm_b, imm_j;
        logic [31:0] rs1v, rs2v;
        logic        wen;
        logic        cond;
        w     = prog[m_pc[7:2]];
        rs1v  = m_regs[w[19:15]];
        rs2v  = m_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        wen      = 1'b0;
        cond     = 1'b0;
        exp_data = 32'd0;
        exp_next = m_pc + 32'd4;
        case (w[6:0])
            7'b0110011: begin
                wen      = 1'b1;
                exp_data = alu_ref(w[14:12], w[30], rs1v, rs2v);
            end
            7'b0010011: begin
                wen      = 1'b1;
                exp_data = alu_ref(w[14:12], w[14:12] == 3'd5 && w[30], rs1v, imm_i);
            end
            7'b0110111: begin
                wen      = 1'b1;
                exp_data = {w[31:12], 12'd0};
            end
            7'b0010111: begin
                wen      = 1'b1;
                exp_data = m_pc + {w[31:12], 12'd0};
            end
            7'b1101111: begin
                wen      = 1'b1;
                exp_data = m_pc + 32'd4;
                exp_next = m_pc + imm_j;
            end
            7'b1100111: begin
                wen      = 1'b1;
                exp_data = m_pc + 32'd4;
                exp_next = (rs1v + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                case (w[14:12])
                    3'd0:    cond = rs1v == rs2v;
                    3'd1:    cond = rs1v != rs2v;
                    3'd4:    cond = $signed(rs1v) < $signed(rs2v);
                    3'd5:    cond = $signed(rs1v) >= $signed(rs2v);
                    3'd6:    cond = rs1v < rs2v;
                    default: cond = rs1v >= rs2v;
                endcase
                if (cond) exp_next = m_pc + imm_b;
            end
            default: ;
        endcase
        exp_rd  = w[11:7];
        exp_wen = wen && exp_rd != 5'd0;
    end

    // A record is consumed at an edge with commit_ready high.
    always @(posedge clk) begin
        if (!rst_n) begin
            m_pc <= RESET_PC;
            for (int i = 0; i < 32; i++) m_regs[i] <= 32'd0;
        end else if (commit_valid && commit_ready) begin
            m_pc    <= exp_next;
            commits <= commits + 1;
            if (exp_wen) m_regs[exp_rd] <= exp_data;  // x0 never written.
            if (commit_pc == loop_pc) loop_hits <= loop_hits + 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    pc_check_a: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && commit_ready |-> commit_pc == m_pc)
        else begin
            mismatches++;
            $display("mismatch %0t: commit_pc %h, expected %h", $time, commit_pc, m_pc);
        end

    wen_check_a: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && commit_ready |-> commit_wen == exp_wen)
        else begin
            mismatches++;
            $display("mismatch %0t: commit_wen %b at pc %h", $time, commit_wen, m_pc);
        end

    data_check_a: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && commit_ready && exp_wen |->
            commit_rd == exp_rd && commit_data == exp_data)
        else begin
            mismatches++;
            $display("mismatch %0t: x%0d = %h, expected x%0d = %h", $time,
                     commit_rd, commit_data, exp_rd, exp_data);
        end

    hold_check_a: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_pc) &&
            $stable(commit_rd) && $stable(commit_wen) && $stable(commit_data))
        else begin
            mismatches++;
            $display("mismatch %0t: commit record changed under back-pressure", $time);
        end

    reset_check_a: assert property (@(posedge clk)
        rst_n && $past(!rst_n) |-> !commit_valid && !commit_wen && fetch_pc == RESET_PC)
        else begin
            mismatches++;
            $display("mismatch %0t: state after reset, fetch_pc %h", $time, fetch_pc);
        end

    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic b0, b1;
        inst_valid   = 1'b0;
        commit_ready = 1'b0;
        wait (rst_n);
        while (loop_hits < 3) begin
            @(posedge clk);
            lfsr = lfsr_next(lfsr);
            b0   = lfsr[0];
            lfsr = lfsr_next(lfsr);
            b1   = lfsr[0];
            inst_valid <= b0 | b1;
            lfsr = lfsr_next(lfsr);
            b0   = lfsr[0];
            lfsr = lfsr_next(lfsr);
            b1   = lfsr[0];
            commit_ready <= b0 | b1;
        end
        repeat (4) @(posedge clk);
        $display("errors: %0d mismatches, %0d other, %0d commits",
                 mismatches, other_errors, commits);
        if (mismatches == 0 && other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog, 40 cycles per instruction with room for stalls.
    initial begin
        #1;
        #(prog_len * 40 * 3 * 10);
        other_errors++;
        $display("timeout: the self-loop was not reached, the pipeline appears hung");
        $display("errors: %0d mismatches, %0d other, %0d commits",
                 mismatches, other_errors, commits);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  rv_exec_pkg::word_t   a,
    input  rv_exec_pkg::word_t   b,
    input  rv_exec_pkg::alu_op_t op,
    output rv_exec_pkg::word_t   result
);
    import rv_exec_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {31'd0, $signed(a) < $signed(b)};
            alu_sltu: result = {31'd0, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $signed(a) >>> shamt;
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            alu_eq:   result = {31'd0, a == b};
            default:  result = '0;
        endcase
    end

endmodule

// ==== source/exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    inst_clear,
    input  logic                    valid_last,
    output logic                    ready_last,
    input  logic                    ready_next,
    output logic                    valid_next,
    input  rv_exec_pkg::word_t      pc,
    input  rv_exec_pkg::word_t      inst,
    input  rv_exec_pkg::reg_idx_t   rd,
    input  logic                    rd_wen,
    input  rv_exec_pkg::funct3_t    funct3,
    input  rv_exec_pkg::word_t      imm_raw,
    input  rv_exec_pkg::imm_kind_t  imm_kind,
    input  rv_exec_pkg::alu_op_t    alu_op,
    input  logic                    inv_flag,
    input  rv_exec_pkg::flow_t      flow,
    input  rv_exec_pkg::src1_sel_t  src1_sel,
    input  rv_exec_pkg::src2_sel_t  src2_sel,
    input  rv_exec_pkg::word_t      rs1_value,
    input  rv_exec_pkg::word_t      rs2_value,
    output rv_exec_pkg::word_t      pc_next,
    output rv_exec_pkg::word_t      inst_next,
    output rv_exec_pkg::reg_idx_t   rd_next,
    output logic                    rd_wen_next,
    output rv_exec_pkg::flow_t      flow_next,
    output rv_exec_pkg::word_t      imm_value,
    output rv_exec_pkg::word_t      rs1_value_next,
    output rv_exec_pkg::word_t      ex_result
);
    import rv_exec_pkg::*;

    word_t     imm_raw_r;
    imm_kind_t imm_kind_r;
    alu_op_t   alu_op_r;
    logic      inv_flag_r;
    src1_sel_t src1_sel_r;
    src2_sel_t src2_sel_r;
    word_t     rs2_value_r;
    word_t     op_a;
    word_t     op_b;
    word_t     alu_result;

    assign ready_last = ready_next;

    // ~~~~~~~~~~~~~~~~~~~~
    // Control fields. A squash captures a bubble.
    always_ff @(posedge clk) begin
        if (!rst_n || inst_clear) begin
            valid_next  <= 1'b0;
            rd_wen_next <= 1'b0;
            flow_next   <= flow_seq;
            inst_next   <= '0;
        end else if (ready_next) begin
            valid_next  <= valid_last;
            rd_wen_next <= valid_last && rd_wen;
            flow_next   <= valid_last ? flow : flow_seq;
            inst_next   <= valid_last ? inst : '0;
        end
    end

    // Payload, loaded only on a transfer.
    always_ff @(posedge clk) begin
        if (valid_last && ready_next) begin
            pc_next        <= pc;
            rd_next        <= rd;
            imm_raw_r      <= imm_raw;
            imm_kind_r     <= imm_kind;
            alu_op_r       <= alu_op;
            inv_flag_r     <= inv_flag;
            src1_sel_r     <= src1_sel;
            src2_sel_r     <= src2_sel;
            rs1_value_next <= rs1_value;
            rs2_value_r    <= rs2_value;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (imm_kind_r)
            imm_i:   imm_value = {{20{imm_raw_r[11]}}, imm_raw_r[11:0]};
            imm_u:   imm_value = {imm_raw_r[19:0], 12'd0};
            imm_b:   imm_value = {{19{imm_raw_r[11]}}, imm_raw_r[11:0], 1'b0};
            imm_j:   imm_value = {{11{imm_raw_r[19]}}, imm_raw_r[19:0], 1'b0};
            default: imm_value = '0;
        endcase
    end

    always_comb begin
        case (src1_sel_r)
            src1_reg: op_a = rs1_value_next;
            src1_pc:  op_a = pc_next;
            default:  op_a = '0;
        endcase
        case (src2_sel_r)
            src2_imm: op_b = imm_value;
            src2_reg: op_b = rs2_value_r;
            default:  op_b = '0;
        endcase
    end

    alu alu0 (
        .a      (op_a),
        .b      (op_b),
        .op     (alu_op_r),
        .result (alu_result)
    );

    assign ex_result = alu_result ^ {31'd0, inv_flag_r};  // Flips compares for BNE/BGE/BGEU.

    no_wen_bubble_a: assert property (@(posedge clk) disable iff (!rst_n)
        !valid_next |-> !rd_wen_next)
        else $error("register write enabled on a bubble");

endmodule

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder #(
    parameter rv_exec_pkg::word_t RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output rv_exec_pkg::word_t      fetch_pc,
    input  rv_exec_pkg::word_t      inst,
    input  logic                    inst_valid,
    input  logic                    redirect,
    input  rv_exec_pkg::word_t      redirect_pc,
    output logic                    valid,
    input  logic                    ready,
    output rv_exec_pkg::reg_idx_t   rs1,
    output rv_exec_pkg::reg_idx_t   rs2,
    input  rv_exec_pkg::word_t      rs1_value_in,
    input  rv_exec_pkg::word_t      rs2_value_in,
    output rv_exec_pkg::word_t      pc,
    output rv_exec_pkg::reg_idx_t   rd,
    output logic                    rd_wen,
    output rv_exec_pkg::funct3_t    funct3,
    output rv_exec_pkg::word_t      imm_raw,
    output rv_exec_pkg::imm_kind_t  imm_kind,
    output rv_exec_pkg::alu_op_t    alu_op,
    output logic                    inv_flag,
    output rv_exec_pkg::flow_t      flow,
    output rv_exec_pkg::src1_sel_t  src1_sel,
    output rv_exec_pkg::src2_sel_t  src2_sel,
    output rv_exec_pkg::word_t      rs1_value,
    output rv_exec_pkg::word_t      rs2_value
);
    import rv_exec_pkg::*;

    word_t pc_r;
    logic  wen;

    function automatic alu_op_t alu_from_f3(input funct3_t f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // A redirect edge loads the target and drops the fetched word.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_r <= RESET_PC;
        end else if (redirect) begin
            pc_r <= redirect_pc;
        end else if (valid && ready) begin
            pc_r <= pc_r + 32'd4;
        end
    end

    assign fetch_pc  = pc_r;
    assign pc        = pc_r;
    assign valid     = inst_valid && !redirect;
    assign rs1       = inst[19:15];
    assign rs2       = inst[24:20];
    assign rd        = inst[11:7];
    assign funct3    = inst[14:12];
    assign rd_wen    = wen && rd != '0;
    assign rs1_value = rs1_value_in;
    assign rs2_value = rs2_value_in;

    always_comb begin
        imm_raw  = '0;
        imm_kind = imm_none;
        alu_op   = alu_add;
        inv_flag = 1'b0;
        flow     = flow_seq;
        src1_sel = src1_reg;
        src2_sel = src2_zero;
        wen      = 1'b0;
        case (inst[6:0])
            7'b0110011: begin                                  // OP.
                src2_sel = src2_reg;
                alu_op   = alu_from_f3(funct3, inst[30]);
                wen      = 1'b1;
            end
            7'b0010011: begin                                  // OP-IMM.
                src2_sel = src2_imm;
                imm_kind = imm_i;
                imm_raw  = {20'd0, inst[31:20]};
                alu_op   = alu_from_f3(funct3, funct3 == 3'b101 && inst[30]);
                wen      = 1'b1;
            end
            7'b0110111, 7'b0010111: begin                      // LUI, AUIPC.
                src1_sel = inst[5] ? src1_zero : src1_pc;
                src2_sel = src2_imm;
                imm_kind = imm_u;
                imm_raw  = {12'd0, inst[31:12]};
                wen      = 1'b1;
            end
            7'b1101111: begin                                  // JAL.
                src1_sel = src1_pc;
                src2_sel = src2_imm;
                imm_kind = imm_j;
                imm_raw  = {12'd0, inst[31], inst[19:12], inst[20], inst[30:21]};
                flow     = flow_jump;
                wen      = 1'b1;
            end
            7'b1100111: begin                                  // JALR.
                src2_sel = src2_imm;
                imm_kind = imm_i;
                imm_raw  = {20'd0, inst[31:20]};
                flow     = flow_jump;
                wen      = 1'b1;
            end
            7'b1100011: begin
                // Compare, then invert for BNE, BGE and BGEU.
                src2_sel = src2_reg;
                imm_kind = imm_b;
                imm_raw  = {20'd0, inst[31], inst[7], inst[30:25], inst[11:8]};
                flow     = flow_branch;
                inv_flag = funct3[0];
                case (funct3[2:1])
                    2'b10:   alu_op = alu_slt;
                    2'b11:   alu_op = alu_sltu;
                    default: alu_op = alu_eq;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_exec_pkg::reg_idx_t rs1,
    input  rv_exec_pkg::reg_idx_t rs2,
    output rv_exec_pkg::word_t   rs1_value,
    output rv_exec_pkg::word_t   rs2_value,
    input  logic                 wr_en,
    input  rv_exec_pkg::reg_idx_t wr_idx,
    input  rv_exec_pkg::word_t   wr_data
);
    import rv_exec_pkg::*;

    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Same-cycle write is forwarded to the reads.
    always_comb begin
        if (rs1 == '0)                     rs1_value = '0;
        else if (wr_en && wr_idx == rs1)   rs1_value = wr_data;
        else                               rs1_value = regs[rs1];
        if (rs2 == '0)                     rs2_value = '0;
        else if (wr_en && wr_idx == rs2)   rs2_value = wr_data;
        else                               rs2_value = regs[rs2];
    end

    // x0 reads zero even in the cycle it is written.
    x0_zero_a: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1 == '0 |-> rs1_value == '0) and (rs2 == '0 |-> rs2_value == '0))
        else $error("x0 read back nonzero");

endmodule

// ==== source/rv_exec_core.sv ====
`timescale 1ns/1ps

module rv_exec_core #(
    parameter rv_exec_pkg::word_t RESET_PC = '0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    output rv_exec_pkg::word_t    fetch_pc,
    input  rv_exec_pkg::word_t    inst,
    input  logic                  inst_valid,
    input  logic                  commit_ready,
    output logic                  commit_valid,
    output rv_exec_pkg::word_t    commit_pc,
    output rv_exec_pkg::reg_idx_t commit_rd,
    output logic                  commit_wen,
    output rv_exec_pkg::word_t    commit_data
);
    import rv_exec_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // Decode to execute.
    logic      dec_valid, dec_ready, dec_rd_wen, dec_inv_flag;
    word_t     dec_pc, dec_imm_raw, dec_rs1_value, dec_rs2_value;
    reg_idx_t  dec_rs1, dec_rs2, dec_rd;
    funct3_t   dec_funct3;
    imm_kind_t dec_imm_kind;
    alu_op_t   dec_alu_op;
    flow_t     dec_flow;
    src1_sel_t dec_src1_sel;
    src2_sel_t dec_src2_sel;
    word_t     rf_rs1_value, rf_rs2_value;

    // Execute to writeback.
    logic      ex_valid, ex_rd_wen, wb_ready;
    word_t     ex_pc, ex_inst, ex_imm_value, ex_rs1_value, ex_result;
    reg_idx_t  ex_rd;
    flow_t     ex_flow;

    logic      redirect, wr_en;
    word_t     redirect_pc, wr_data;
    reg_idx_t  wr_idx;

    inst_decoder #(.RESET_PC(RESET_PC)) dec0 (
        .clk(clk), .rst_n(rst_n), .fetch_pc(fetch_pc), .inst(inst),
        .inst_valid(inst_valid), .redirect(redirect), .redirect_pc(redirect_pc),
        .valid(dec_valid), .ready(dec_ready), .rs1(dec_rs1), .rs2(dec_rs2),
        .rs1_value_in(rf_rs1_value), .rs2_value_in(rf_rs2_value),
        .pc(dec_pc), .rd(dec_rd), .rd_wen(dec_rd_wen), .funct3(dec_funct3),
        .imm_raw(dec_imm_raw), .imm_kind(dec_imm_kind), .alu_op(dec_alu_op),
        .inv_flag(dec_inv_flag), .flow(dec_flow), .src1_sel(dec_src1_sel),
        .src2_sel(dec_src2_sel), .rs1_value(dec_rs1_value), .rs2_value(dec_rs2_value)
    );

    reg_file rf0 (
        .clk(clk), .rst_n(rst_n), .rs1(dec_rs1), .rs2(dec_rs2),
        .rs1_value(rf_rs1_value), .rs2_value(rf_rs2_value),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
    );

    // The fetched word goes to execute as is.
    exec_stage ex0 (
        .clk(clk), .rst_n(rst_n), .inst_clear(redirect),
        .valid_last(dec_valid), .ready_last(dec_ready),
        .ready_next(wb_ready), .valid_next(ex_valid),
        .pc(dec_pc), .inst(inst), .rd(dec_rd), .rd_wen(dec_rd_wen),
        .funct3(dec_funct3), .imm_raw(dec_imm_raw), .imm_kind(dec_imm_kind),
        .alu_op(dec_alu_op), .inv_flag(dec_inv_flag), .flow(dec_flow),
        .src1_sel(dec_src1_sel), .src2_sel(dec_src2_sel),
        .rs1_value(dec_rs1_value), .rs2_value(dec_rs2_value),
        .pc_next(ex_pc), .inst_next(ex_inst), .rd_next(ex_rd), .rd_wen_next(ex_rd_wen),
        .flow_next(ex_flow), .imm_value(ex_imm_value), .rs1_value_next(ex_rs1_value),
        .ex_result(ex_result)
    );

    writeback_stage wb0 (
        .clk(clk), .rst_n(rst_n), .valid(ex_valid), .ready(wb_ready),
        .commit_ready(commit_ready), .pc(ex_pc), .inst(ex_inst), .rd(ex_rd),
        .rd_wen(ex_rd_wen), .flow(ex_flow), .imm_value(ex_imm_value),
        .rs1_value(ex_rs1_value), .ex_result(ex_result),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_rd(commit_rd),
        .commit_wen(commit_wen), .commit_data(commit_data)
    );

endmodule

// ==== source/rv_exec_pkg.sv ====
package rv_exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // ALU operations. Compares give 0 or 1.
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_eq
    } alu_op_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Immediate layouts carried in imm_raw.
    typedef enum logic [2:0] {
        imm_i,    // Sign-extended 12 bits.
        imm_u,    // 20 bits up by 12.
        imm_b,    // Branch offset, halfword units.
        imm_j,    // Jump offset, halfword units.
        imm_none
    } imm_kind_t;

    typedef enum logic [1:0] {
        src1_reg,
        src1_pc,
        src1_zero
    } src1_sel_t;

    typedef enum logic [1:0] {
        src2_imm,
        src2_reg,
        src2_zero
    } src2_sel_t;

    typedef enum logic [1:0] {
        flow_seq,
        flow_jump,
        flow_branch
    } flow_t;

endpackage

// ==== source/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid,
    output logic                  ready,
    input  logic                  commit_ready,
    input  rv_exec_pkg::word_t    pc,
    input  rv_exec_pkg::word_t    inst,
    input  rv_exec_pkg::reg_idx_t rd,
    input  logic                  rd_wen,
    input  rv_exec_pkg::flow_t    flow,
    input  rv_exec_pkg::word_t    imm_value,
    input  rv_exec_pkg::word_t    rs1_value,
    input  rv_exec_pkg::word_t    ex_result,
    output logic                  redirect,
    output rv_exec_pkg::word_t    redirect_pc,
    output logic                  wr_en,
    output rv_exec_pkg::reg_idx_t wr_idx,
    output rv_exec_pkg::word_t    wr_data,
    output logic                  commit_valid,
    output rv_exec_pkg::word_t    commit_pc,
    output rv_exec_pkg::reg_idx_t commit_rd,
    output logic                  commit_wen,
    output rv_exec_pkg::word_t    commit_data
);
    import rv_exec_pkg::*;

    logic retire;
    logic taken;
    logic is_jalr;

    assign ready   = commit_ready;
    assign retire  = valid && commit_ready;
    assign is_jalr = !inst[3];                            // JALR opcode has bit 3 clear.
    assign taken   = flow == flow_jump || (flow == flow_branch && ex_result[0]);

    assign redirect    = retire && taken;
    assign redirect_pc = (flow == flow_jump && is_jalr) ?
                         ((rs1_value + imm_value) & ~32'd1) : pc + imm_value;

    assign wr_en   = retire && rd_wen;
    assign wr_idx  = rd;
    assign wr_data = (flow == flow_jump) ? pc + 32'd4 : ex_result;  // Link address.

    // ~~~~~~~~~~~~~~~~~~~~
    // Commit record holds while the consumer stalls.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
            commit_wen   <= 1'b0;
        end else if (commit_ready) begin
            commit_valid <= valid;
            commit_wen   <= valid && rd_wen;
        end
    end

    always_ff @(posedge clk) begin
        if (commit_ready) begin
            commit_pc   <= pc;
            commit_rd   <= rd;
            commit_data <= wr_data;
        end
    end

    // The squashed slot behind a redirect must be a bubble.
    redirect_bubble_a: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> valid ##1 !valid)
        else $error("wrong-path instruction reached writeback");

endmodule

// ==== sources.f ====
source/rv_exec_pkg.sv
source/reg_file.sv
source/alu.sv
source/inst_decoder.sv
source/exec_stage.sv
source/writeback_stage.sv
source/rv_exec_core.sv
sim/tb_clock.sv
sim/tb_rv_exec.sv
